/* Makefile */
TOP := icache_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f icache.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

/* bench/icache_sva.sv */
// checks only the bus read handshake and the data strobe, refill beats are checked by the testbench

module icache_sva (
  input logic        i_clk,
  input logic        i_rst,
  input logic        o_data_ok,
  input logic        o_rd_req,
  input logic [31:0] o_rd_addr,
  input logic        i_rd_rdy
);

  // line read stays up with a fixed address until the bus takes it
  property rd_req_held;
    @(posedge i_clk) disable iff (i_rst)
      (o_rd_req && !i_rd_rdy) |=> (o_rd_req && $stable(o_rd_addr));
  endproperty

  a_rd_req_held: assert property (rd_req_held)
    else $error("line read dropped or changed before i_rd_rdy");

  a_no_overlap: assert property (@(posedge i_clk) disable iff (i_rst) !(o_data_ok && o_rd_req))
    else $error("o_data_ok and o_rd_req high in the same cycle");

  a_reset_idle: assert property (@(posedge i_clk) i_rst |=> !o_rd_req)
    else $error("o_rd_req high in the cycle after reset");

endmodule

bind icache_top icache_sva u_sva (
  .i_clk     (i_clk),
  .i_rst     (i_rst),
  .o_data_ok (o_data_ok),
  .o_rd_req  (o_rd_req),
  .o_rd_addr (o_rd_addr),
  .i_rd_rdy  (i_rd_rdy)
);

/* bench/icache_tb.sv */
// bus model returns beats in line order only after i_rd_rdy, and the tag model keeps one rr bit

`include "icache_defines.svh"

module icache_tb;

  import icache_pkg::*;

  localparam int TOTAL_REQS  = 27;
  localparam int CYCLE_LIMIT = 40 * TOTAL_REQS + 200;

  logic                      i_clk = 1'b0;
  logic                      i_rst;
  logic                      i_valid;
  icache_tag_t               i_tag;
  icache_index_t             i_index;
  icache_offset_t            i_offset;
  logic                      o_addr_ok;
  logic                      o_data_ok;
  icache_word_t              o_rdata;
  logic                      o_rd_req;
  logic [`ICACHE_ADDR_W-1:0] o_rd_addr;
  logic                      i_rd_rdy;
  logic                      i_ret_valid;
  logic                      i_ret_last;
  icache_word_t              i_ret_data;

  int          cycle = 0;
  int          data_errors = 0;
  int          proto_errors = 0;
  int          resp_count = 0;
  int          extra_wait = 0;       // added bus delay for back-pressure
  logic [31:0] rng = 32'h809fc46e;
  logic [31:0] exp_addr [$];         // accepted requests in order
  logic        exp_miss [$];
  int          exp_cycle [$];
  logic        got_read;             // bus read seen for the oldest miss
  logic        prev_req;
  logic        prev_rdy;
  logic [31:0] prev_addr;
  logic        m_valid [`ICACHE_WAYS][`ICACHE_SETS];
  icache_tag_t m_tag [`ICACHE_WAYS][`ICACHE_SETS];
  logic        m_rr;

  icache_top i_dut (.*);

  always #50 i_clk = ~i_clk;

  // -------------------------------------------------------------------------
  // reference model
  // -------------------------------------------------------------------------

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic icache_word_t mem_word(input logic [28:0] waddr);
    logic [31:0] a;
    a = {3'b000, waddr};
    return {a * 32'h9e3779b1, a ^ 32'hc3a50f96};  // every address bit matters
  endfunction

  function automatic icache_word_t ref_word(input logic [31:0] addr);
    return mem_word(addr[31:3]);
  endfunction

  // empty way first or else the rr bit that flips on every refill
  function automatic logic predict_miss(input logic [31:0] addr);
    icache_index_t idx;
    icache_tag_t   tg;
    logic          way;
    idx = addr[10:5];
    tg  = addr[31:11];
    if ((m_valid[0][idx] && m_tag[0][idx] == tg) ||
        (m_valid[1][idx] && m_tag[1][idx] == tg)) begin
      return 1'b0;
    end
    if (!m_valid[0][idx]) begin
      way = 1'b0;
    end else if (!m_valid[1][idx]) begin
      way = 1'b1;
    end else begin
      way = m_rr;
    end
    m_valid[way][idx] = 1'b1;
    m_tag[way][idx]   = tg;
    m_rr              = ~m_rr;
    return 1'b1;
  endfunction

  // -------------------------------------------------------------------------
  // comparison
  // -------------------------------------------------------------------------

  task automatic record_accept();
    logic [31:0] addr;
    addr = {i_tag, i_index, i_offset};
    exp_addr.push_back(addr);
    exp_miss.push_back(predict_miss(addr));
    exp_cycle.push_back(cycle);
  endtask

  task automatic check_line_read();
    logic pending;
    pending = (exp_addr.size() != 0) && exp_miss[0];
    assert (pending) else begin
      proto_errors++;
      $display("bus read at %0t without a pending miss", $time);
    end
    if (pending) begin
      assert (o_rd_addr == {exp_addr[0][31:5], 5'b0}) else begin
        data_errors++;
        $display("Mismatch at %0t: line read address %h, expected %h",
                 $time, o_rd_addr, {exp_addr[0][31:5], 5'b0});
      end
      assert (!got_read) else begin
        proto_errors++;
        $display("second bus read at %0t for one miss", $time);
      end
      got_read = 1'b1;
    end
  endtask

  task automatic check_response();
    logic [31:0] addr;
    logic        miss;
    int          acc;
    assert (exp_addr.size() != 0) else begin
      proto_errors++;
      $display("o_data_ok at %0t with no request pending", $time);
    end
    if (exp_addr.size() != 0) begin
      addr = exp_addr.pop_front();
      miss = exp_miss.pop_front();
      acc  = exp_cycle.pop_front();
      resp_count++;
      assert (o_rdata == ref_word(addr)) else begin
        data_errors++;
        $display("Mismatch at %0t: read of %h returned %h, expected %h",
                 $time, addr, o_rdata, ref_word(addr));
      end
      if (miss) begin
        assert (got_read) else begin
          proto_errors++;
          $display("miss at %h returned data without a bus read", addr);
        end
      end else begin
        assert (cycle == acc + 1) else begin
          proto_errors++;
          $display("hit at %h answered %0d cycles after acceptance", addr, cycle - acc);
        end
      end
      got_read = 1'b0;
    end
  endtask

  always @(posedge i_clk) begin
    if (!i_rst) begin
      assert (!(o_data_ok && o_rd_req)) else begin
        proto_errors++;
        $display("o_data_ok and o_rd_req together at %0t", $time);
      end
      if (o_rd_req) begin
        assert (!o_addr_ok) else begin
          proto_errors++;
          $display("request could be accepted during a miss at %0t", $time);
        end
      end
      if (prev_req && !prev_rdy) begin
        assert (o_rd_req && o_rd_addr == prev_addr) else begin
          proto_errors++;
          $display("line read not held stable until i_rd_rdy at %0t", $time);
        end
      end
      if (o_rd_req && i_rd_rdy) check_line_read();
      if (o_data_ok) check_response();
      if (i_valid && o_addr_ok) record_accept();
    end
    prev_req  <= o_rd_req;
    prev_rdy  <= i_rd_rdy;
    prev_addr <= o_rd_addr;
  end

  always @(posedge i_clk) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles without finishing", cycle);
      $display("Finished with errors");
      $finish;
    end
  end

  // -------------------------------------------------------------------------
  // bus memory model
  // -------------------------------------------------------------------------

  initial begin : bus_model
    int          wait_cycles;
    logic [31:0] line_addr;
    i_rd_rdy    = 1'b0;
    i_ret_valid = 1'b0;
    i_ret_last  = 1'b0;
    i_ret_data  = '0;
    forever begin
      @(negedge i_clk);
      if (o_rd_req) begin
        rng = lcg_step(rng);
        wait_cycles = extra_wait + rng[17:16];  // 0 to 3 plus back-pressure
        repeat (wait_cycles) @(negedge i_clk);
        i_rd_rdy  = 1'b1;
        line_addr = o_rd_addr;
        @(negedge i_clk);
        i_rd_rdy = 1'b0;
        for (int b = 0; b < `ICACHE_BEATS; b++) begin
          rng = lcg_step(rng);
          if (rng[20]) @(negedge i_clk);  // one-cycle gap
          i_ret_valid = 1'b1;
          i_ret_last  = (b == `ICACHE_BEATS - 1);
          i_ret_data  = mem_word({line_addr[31:5], b[1:0]});
          @(negedge i_clk);
          i_ret_valid = 1'b0;
          i_ret_last  = 1'b0;
        end
      end
    end
  end

  // -------------------------------------------------------------------------
  // stimulus
  // -------------------------------------------------------------------------

  // returns in the cycle after acceptance with i_valid still high
  task automatic send_req(input logic [31:0] addr);
    i_valid  = 1'b1;
    i_tag    = addr[31:11];
    i_index  = addr[10:5];
    i_offset = addr[4:0];
    while (!o_addr_ok) @(negedge i_clk);
    @(negedge i_clk);
  endtask

  task automatic drain_reqs();
    i_valid = 1'b0;
    while (exp_addr.size() != 0) @(negedge i_clk);
  endtask

  task automatic single_req(input logic [31:0] addr);
    send_req(addr);
    drain_reqs();
  endtask

  initial begin : stimulus
    logic [31:0] lines [4];
    int          order [7];
    int          start;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        m_valid[w][s] = 1'b0;
      end
    end
    m_rr     = 1'b0;
    got_read = 1'b0;
    i_rst    = 1'b1;
    i_valid  = 1'b0;
    i_tag    = '0;
    i_index  = '0;
    i_offset = '0;
    repeat (4) @(negedge i_clk);
    i_rst = 1'b0;
    @(negedge i_clk);
    assert (!o_data_ok && !o_rd_req && o_addr_ok) else begin
      proto_errors++;
      $display("outputs not idle after reset: data_ok %b rd_req %b addr_ok %b",
               o_data_ok, o_rd_req, o_addr_ok);
    end
    lines[0] = {21'h00a11, 6'd1, 5'd0};
    lines[1] = {21'h1b2c3, 6'd2, 5'd13};
    lines[2] = {21'h0f00f, 6'd3, 5'd16};
    lines[3] = {21'h15555, 6'd4, 5'd31};  // critical word is beat 3
    for (int i = 0; i < 4; i++) single_req(lines[i]);
    for (int i = 0; i < 4; i++) single_req(lines[i] ^ 32'h8);
    start = cycle;
    for (int i = 0; i < 8; i++) send_req({lines[i % 4][31:5], i[1:0], 3'b101});
    assert (cycle == start + 8) else begin
      proto_errors++;
      $display("back-to-back hits took %0d cycles to accept", cycle - start);
    end
    drain_reqs();
    single_req({21'h0c0de, 6'd8, 5'd0});  // one more miss leaves the rr bit set
    // three tags in set 9
    order = '{0, 1, 2, 1, 0, 2, 0};
    for (int k = 0; k < 7; k++) single_req({11'h100, order[k][9:0], 6'd9, 5'd8});
    extra_wait = 8;
    send_req({21'h0abcd, 6'd20, 5'd8});
    send_req({21'h13579, 6'd21, 5'd24});  // held off by the first miss
    send_req({21'h0abcd, 6'd20, 5'd0});
    drain_reqs();
    extra_wait = 0;
    $display("responses %0d, data errors %0d, protocol errors %0d",
             resp_count, data_errors, proto_errors);
    if (data_errors == 0 && proto_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* design/icache_ctrl.sv */
// blocking controller that serves one miss at a time and needs i_rd_rdy before any refill beat

`include "icache_defines.svh"

module icache_ctrl (
  input  logic                        i_clk,
  input  logic                        i_rst,
  // cpu request
  input  logic                        i_valid,
  input  icache_pkg::icache_tag_t     i_tag,
  input  icache_pkg::icache_index_t   i_index,
  input  icache_pkg::icache_offset_t  i_offset,
  output logic                        o_addr_ok,
  output logic                        o_data_ok,
  output icache_pkg::icache_word_t    o_rdata,
  // array results
  input  logic                        i_hit,
  input  logic                        i_victim_way,
  input  icache_pkg::icache_word_t    i_hit_word,
  output icache_pkg::icache_tag_t     o_req_tag,
  output icache_pkg::icache_beat_t    o_word_sel,
  icache_fill_if.ctrl                 fill,
  // bus side
  output logic                        o_rd_req,
  output logic [`ICACHE_ADDR_W-1:0]   o_rd_addr,
  input  logic                        i_rd_rdy,
  input  logic                        i_ret_valid,
  input  logic                        i_ret_last,
  input  icache_pkg::icache_word_t    i_ret_data
);

  import icache_pkg::*;

  icache_state_e state_q;
  icache_state_e state_d;
  icache_addr_u  req_q;      // request buffer
  icache_addr_u  line_addr;  // line-aligned miss address
  logic          victim_q;   // way chosen at the miss
  icache_beat_t  beat_q;     // refill beats received
  logic          accept;
  logic          in_lookup;
  logic          in_refill;

  assign in_lookup = (state_q == LOOKUP);
  assign in_refill = (state_q == REFILL);

  // ---------------------------------------------------------------------------
  // cpu handshake and request buffer
  // ---------------------------------------------------------------------------

  assign o_addr_ok = (state_q == IDLE) || (in_lookup && i_hit);
  assign accept    = i_valid && o_addr_ok;

  always_ff @(posedge i_clk) begin
    if (accept) begin
      req_q.f.tag    <= i_tag;
      req_q.f.index  <= i_index;
      req_q.f.offset <= i_offset;
    end
  end

  assign o_req_tag  = req_q.f.tag;
  assign o_word_sel = req_q.f.offset[4:3];  // word within the line

  // ---------------------------------------------------------------------------
  // state machine
  // ---------------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (i_valid) state_d = LOOKUP;
      LOOKUP: begin
        if (!i_hit) begin
          state_d = REPLACE;
        end else if (!i_valid) begin
          state_d = IDLE;  // stays in LOOKUP on back-to-back hits
        end
      end
      REPLACE: if (i_rd_rdy) state_d = REFILL;
      REFILL:  if (i_ret_valid && i_ret_last) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q  <= IDLE;
      victim_q <= 1'b0;
      beat_q   <= '0;
    end else begin
      state_q <= state_d;
      if (in_lookup && !i_hit) begin
        victim_q <= i_victim_way;  // hold the way for the whole refill
      end
      if (state_q == REPLACE) begin
        beat_q <= '0;
      end else if (in_refill && i_ret_valid) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // array controls and bus request
  // ---------------------------------------------------------------------------

  assign fill.rd_index  = accept ? i_index : req_q.f.index;
  assign fill.fill_en   = in_refill && i_ret_valid;
  assign fill.fill_way  = victim_q;
  assign fill.fill_beat = beat_q;
  assign fill.fill_last = in_refill && i_ret_valid && i_ret_last;

  always_comb begin
    line_addr.f.tag    = req_q.f.tag;
    line_addr.f.index  = req_q.f.index;
    line_addr.f.offset = '0;
  end

  assign o_rd_req  = (state_q == REPLACE);
  assign o_rd_addr = line_addr.raw;

  // critical word goes out on the beat that carries it
  assign o_data_ok = (in_lookup && i_hit) ||
                     (in_refill && i_ret_valid && (beat_q == o_word_sel));
  assign o_rdata   = in_lookup ? i_hit_word : i_ret_data;

endmodule

/* design/icache_data_array.sv */
// read of the set being written returns old data, the controller never looks up during a refill

`include "icache_defines.svh"

module icache_data_array (
  input  logic                      i_clk,
  input  icache_pkg::icache_word_t  i_ret_data,
  input  logic                      i_hit_way,
  input  icache_pkg::icache_beat_t  i_word_sel,
  icache_fill_if.array              fill,
  output icache_pkg::icache_word_t  o_hit_word
);

  import icache_pkg::*;

  // ---------------------------------------------------------------------------
  // line storage, one word per beat position
  // ---------------------------------------------------------------------------

  icache_word_t line_mem  [`ICACHE_WAYS][`ICACHE_SETS][`ICACHE_BEATS];
  icache_word_t rd_line_q [`ICACHE_WAYS][`ICACHE_BEATS];  // both ways of the read set

  // refill writes one word per beat into the chosen way
  always_ff @(posedge i_clk) begin
    if (fill.fill_en) begin
      line_mem[fill.fill_way][fill.rd_index][fill.fill_beat] <= i_ret_data;
    end
  end

  // registered read, valid the cycle after rd_index
  always_ff @(posedge i_clk) begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      for (int b = 0; b < `ICACHE_BEATS; b++) begin
        rd_line_q[w][b] <= line_mem[w][fill.rd_index][b];
      end
    end
  end

  // ---------------------------------------------------------------------------
  // hit word select
  // ---------------------------------------------------------------------------

  assign o_hit_word = rd_line_q[i_hit_way][i_word_sel];  // don't care when no way hits

endmodule

/* design/icache_defines.svh */
// geometry is fixed here and every derived width assumes power-of-two sizes

`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// ---------------------------------------------------------------------------
// base geometry of the 4 KiB two-way instruction cache
// ---------------------------------------------------------------------------

`define ICACHE_ADDR_W     32  // bus address width
`define ICACHE_WORD_W     64  // cpu and refill word width
`define ICACHE_LINE_BYTES 32  // bytes per line
`define ICACHE_SETS       64  // sets per way
`define ICACHE_WAYS       2   // associativity, the victim logic expects two
`define ICACHE_BEATS      4   // refill beats per line

// ---------------------------------------------------------------------------
// derived field widths
// ---------------------------------------------------------------------------

`define ICACHE_OFFSET_W ($clog2(`ICACHE_LINE_BYTES))  // 5
`define ICACHE_INDEX_W  ($clog2(`ICACHE_SETS))        // 6
`define ICACHE_TAG_W    (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)  // 21

// word-in-line number, taken from offset bits 4:3
`define ICACHE_BEAT_W   ($clog2(`ICACHE_BEATS))

`endif

/* design/icache_fill_if.sv */
// every signal is driven by the controller and is only read by the arrays

interface icache_fill_if;

  import icache_pkg::*;

  // -------------------------------------------------------------------------
  // array read address
  // -------------------------------------------------------------------------

  icache_index_t rd_index;  // set read this cycle, also the refill set

  // -------------------------------------------------------------------------
  // refill write controls
  // -------------------------------------------------------------------------

  logic          fill_en;    // refill beat present
  logic          fill_way;   // way being refilled
  icache_beat_t  fill_beat;  // word position of the beat
  logic          fill_last;  // final beat, already qualified by fill_en

  modport ctrl (
    output rd_index,
    output fill_en,
    output fill_way,
    output fill_beat,
    output fill_last
  );

  modport array (
    input  rd_index,
    input  fill_en,
    input  fill_way,
    input  fill_beat,
    input  fill_last
  );

endinterface

/* design/icache_pkg.sv */
// types follow the fixed geometry of the defines header and hold no logic

`include "icache_defines.svh"

package icache_pkg;

  // -------------------------------------------------------------------------
  // scalar fields of an address and the data word
  // -------------------------------------------------------------------------

  typedef logic [`ICACHE_WORD_W-1:0]   icache_word_t;    // one 64-bit word
  typedef logic [`ICACHE_TAG_W-1:0]    icache_tag_t;     // addr[31:11]
  typedef logic [`ICACHE_INDEX_W-1:0]  icache_index_t;   // addr[10:5]
  typedef logic [`ICACHE_OFFSET_W-1:0] icache_offset_t;  // addr[4:0]
  typedef logic [`ICACHE_BEAT_W-1:0]   icache_beat_t;    // word within line

  // tag, index and offset in address order
  typedef struct packed {
    icache_tag_t    tag;
    icache_index_t  index;
    icache_offset_t offset;
  } icache_addr_fields_t;

  // same 32 bits seen as a bus address or split into its fields
  typedef union packed {
    logic [`ICACHE_ADDR_W-1:0] raw;
    icache_addr_fields_t       f;
  } icache_addr_u;

  // -------------------------------------------------------------------------
  // controller states
  // -------------------------------------------------------------------------

  typedef enum logic [1:0] {
    IDLE,     // waiting for a request
    LOOKUP,   // tags and data valid from the registered read
    REPLACE,  // line read held on the bus
    REFILL    // beats arriving
  } icache_state_e;

endpackage

/* design/icache_tag_array.sv */
// two ways only, the tag write uses the set on rd_index and it must hold through the refill

`include "icache_defines.svh"

module icache_tag_array (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  icache_pkg::icache_tag_t  i_req_tag,
  icache_fill_if.array             fill,
  output logic                     o_hit,
  output logic                     o_hit_way,
  output logic                     o_victim_way
);

  import icache_pkg::*;

  logic [`ICACHE_SETS-1:0] valid_q [`ICACHE_WAYS];     // valid bit per way and set
  icache_tag_t             tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
  logic [`ICACHE_WAYS-1:0] rd_valid_q;                  // registered read of the set
  icache_tag_t             rd_tag_q [`ICACHE_WAYS];
  logic [`ICACHE_WAYS-1:0] way_hit;
  logic                    rr_q;                        // round-robin victim bit

  // ---------------------------------------------------------------------------
  // storage and registered read
  // ---------------------------------------------------------------------------

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        valid_q[w] <= '0;
      end
      rd_valid_q <= '0;
      rr_q       <= 1'b0;
    end else begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        rd_valid_q[w] <= valid_q[w][fill.rd_index];
      end
      if (fill.fill_last) begin
        valid_q[fill.fill_way][fill.rd_index] <= 1'b1;
        rr_q <= ~rr_q;  // flips once per finished refill
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (fill.fill_last) begin
      tag_mem[fill.fill_way][fill.rd_index] <= i_req_tag;
    end
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      rd_tag_q[w] <= tag_mem[w][fill.rd_index];
    end
  end

  // ---------------------------------------------------------------------------
  // compare and victim choice
  // ---------------------------------------------------------------------------

  always_comb begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      way_hit[w] = rd_valid_q[w] && (rd_tag_q[w] == i_req_tag);
    end
  end

  assign o_hit     = |way_hit;
  assign o_hit_way = way_hit[1];  // way 0 unless way 1 hits

  always_comb begin
    if (!rd_valid_q[0]) begin
      o_victim_way = 1'b0;  // empty way first
    end else if (!rd_valid_q[1]) begin
      o_victim_way = 1'b1;
    end else begin
      o_victim_way = rr_q;
    end
  end

endmodule

/* design/icache_top.sv */
// read-only instruction cache, the bus must return beats in line order with i_ret_last on the fourth

`include "icache_defines.svh"

module icache_top (
  input  logic                        i_clk,
  input  logic                        i_rst,
  // cpu side
  input  logic                        i_valid,
  input  icache_pkg::icache_tag_t     i_tag,
  input  icache_pkg::icache_index_t   i_index,
  input  icache_pkg::icache_offset_t  i_offset,
  output logic                        o_addr_ok,
  output logic                        o_data_ok,
  output icache_pkg::icache_word_t    o_rdata,
  // bus side
  output logic                        o_rd_req,
  output logic [`ICACHE_ADDR_W-1:0]   o_rd_addr,
  input  logic                        i_rd_rdy,
  input  logic                        i_ret_valid,
  input  logic                        i_ret_last,
  input  icache_pkg::icache_word_t    i_ret_data
);

  import icache_pkg::*;

  // ---------------------------------------------------------------------------
  // internal wiring
  // ---------------------------------------------------------------------------

  icache_fill_if fill_bus ();  // read address and refill controls

  logic         hit;
  logic         hit_way;
  logic         victim_way;
  icache_word_t hit_word;
  icache_tag_t  req_tag;
  icache_beat_t word_sel;

  icache_ctrl u_ctrl (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_valid      (i_valid),
    .i_tag        (i_tag),
    .i_index      (i_index),
    .i_offset     (i_offset),
    .o_addr_ok    (o_addr_ok),
    .o_data_ok    (o_data_ok),
    .o_rdata      (o_rdata),
    .i_hit        (hit),
    .i_victim_way (victim_way),
    .i_hit_word   (hit_word),
    .o_req_tag    (req_tag),
    .o_word_sel   (word_sel),
    .fill         (fill_bus.ctrl),
    .o_rd_req     (o_rd_req),
    .o_rd_addr    (o_rd_addr),
    .i_rd_rdy     (i_rd_rdy),
    .i_ret_valid  (i_ret_valid),
    .i_ret_last   (i_ret_last),
    .i_ret_data   (i_ret_data)
  );

  icache_tag_array u_tag (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_req_tag    (req_tag),
    .fill         (fill_bus.array),
    .o_hit        (hit),
    .o_hit_way    (hit_way),
    .o_victim_way (victim_way)
  );

  icache_data_array u_data (
    .i_clk        (i_clk),
    .i_ret_data   (i_ret_data),
    .i_hit_way    (hit_way),
    .i_word_sel   (word_sel),
    .fill         (fill_bus.array),
    .o_hit_word   (hit_word)
  );

endmodule

/* icache.f */
+incdir+design
design/icache_pkg.sv
design/icache_fill_if.sv
design/icache_ctrl.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_top.sv
bench/icache_sva.sv
bench/icache_tb.sv
